/* aes_core.f */
design/aes_pkg.sv
design/aes_cmd_pkg.sv
design/aes_key_schedule.sv
design/aes_round_engine.sv
design/aes_cmd_decode.sv
design/aes_result.sv
design/aes_core.sv
test/tb_clock.sv
test/aes_core_asserts.sv
test/tb_aes_core.sv

/* design/aes_cmd_decode.sv */
// Command decode for the AES-256 core
// Accepts one command at a time and only while no result is pending
// The stored key survives every opcode except key load

module aes_cmd_decode (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             in_valid,
  output logic                             in_ready,
  output logic                             busy,
  input  logic [aes_cmd_pkg::opcode_w-1:0] opcode,
  input  aes_cmd_pkg::cmd_data_t           data_in,
  input  logic                             result_idle,
  output logic                             start,
  output logic [aes_pkg::block_w-1:0]      start_block,
  output logic [aes_pkg::key_w-1:0]        start_key,
  input  logic                             engine_idle,
  output logic                             bypass
);

  logic                             accept;
  logic                             dispatching;
  logic                             waiting;
  logic [aes_cmd_pkg::opcode_w-1:0] op_q;
  logic [aes_pkg::key_w-1:0]        key_q;
  logic [aes_pkg::block_w-1:0]      block_q;

  // ----------------------------------------
  // Input handshake
  // ----------------------------------------
  // Waiting ends as soon as the result has been delivered
  assign in_ready = result_idle && !dispatching && (!waiting || engine_idle);
  assign busy     = !in_ready;
  assign accept   = in_valid && in_ready;

  // One command state
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dispatching <= 1'b0;
      waiting     <= 1'b0;
      op_q        <= '0;
    end else begin
      dispatching <= accept;
      waiting     <= dispatching || (waiting && !(engine_idle && result_idle));
      if (accept) begin
        op_q <= opcode;
      end
    end
  end

  // Key and block storage, decoded through the union
  always_ff @(posedge clk) begin
    if (accept && opcode == aes_cmd_pkg::op_key_load) begin
      key_q <= data_in.key;
    end
    if (accept && opcode == aes_cmd_pkg::op_encrypt) begin
      block_q <= data_in.block.plaintext;
    end
  end

  // ----------------------------------------
  // Dispatch in the cycle after acceptance
  // ----------------------------------------
  assign start       = dispatching && (op_q == aes_cmd_pkg::op_encrypt);
  assign bypass      = dispatching && (op_q != aes_cmd_pkg::op_encrypt);
  assign start_block = block_q;
  assign start_key   = key_q;

endmodule

/* design/aes_cmd_pkg.sv */
// Host command encoding for the AES-256 core
// Opcodes other than key load and encrypt return a zero result
// The 256-bit data word is read either as a key or as a block

package aes_cmd_pkg;

  localparam int opcode_w = 7;

  localparam logic [opcode_w-1:0] op_key_load = 7'd0;
  localparam logic [opcode_w-1:0] op_encrypt  = 7'd1;

  // Encrypt view with the plaintext in the upper half
  typedef struct packed {
    logic [aes_pkg::block_w-1:0]                  plaintext;
    logic [aes_pkg::key_w-aes_pkg::block_w-1:0]   unused;
  } cmd_block_t;

  // Same 256 bits decoded per opcode
  typedef union packed {
    logic [aes_pkg::key_w-1:0] key;
    cmd_block_t                block;
  } cmd_data_t;

endpackage

/* design/aes_core.sv */
// AES-256 encryption core with a command interface
// Latency is 1 cycle for key load and other opcodes, 16 for encrypt
// One command in flight and busy is the inverse of in_ready

module aes_core (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             in_valid,
  output logic                             in_ready,
  input  logic [aes_cmd_pkg::opcode_w-1:0] opcode,
  input  aes_cmd_pkg::cmd_data_t           data_in,
  output logic                             out_valid,
  input  logic                             out_ready,
  output logic [aes_pkg::block_w-1:0]      data_out,
  output logic                             busy
);

  logic                        start;
  logic [aes_pkg::block_w-1:0] start_block;
  logic [aes_pkg::key_w-1:0]   start_key;
  logic                        engine_idle;
  logic                        bypass;
  logic                        done;
  logic [aes_pkg::block_w-1:0] cipher;
  logic                        result_idle;

  aes_cmd_decode u_decode (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .busy        (busy),
    .opcode      (opcode),
    .data_in     (data_in),
    .result_idle (result_idle),
    .start       (start),
    .start_block (start_block),
    .start_key   (start_key),
    .engine_idle (engine_idle),
    .bypass      (bypass)
  );

  aes_round_engine u_engine (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .start_block (start_block),
    .start_key   (start_key),
    .idle        (engine_idle),
    .done        (done),
    .cipher      (cipher)
  );

  aes_result u_result (
    .clk       (clk),
    .rst       (rst),
    .bypass    (bypass),
    .done      (done),
    .cipher    (cipher),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .data_out  (data_out),
    .idle      (result_idle)
  );

endmodule

/* design/aes_key_schedule.sv */
// AES-256 key expansion, one round key per step
// Load presents the key upper half at once and the lower half next
// Steps then alternate even (RotWord and rcon) and odd (SubWord only)

module aes_key_schedule (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        load,
  input  logic [aes_pkg::key_w-1:0]   key,
  input  logic                        step,
  output logic [aes_pkg::block_w-1:0] round_key
);

  logic [aes_pkg::key_w-1:0]         window;
  logic [7:0]                        rcon;
  logic                              phase;
  logic [0:7][aes_pkg::word_w-1:0]   w;
  logic [0:7][aes_pkg::word_w-1:0]   n;
  logic [aes_pkg::word_w-1:0]        sw_in;
  logic [aes_pkg::word_w-1:0]        sw_out;

  assign w = window;

  // Phase high means the lower half is on the output, so an even step is next
  assign sw_in  = phase ? {w[7][aes_pkg::word_w-9:0], w[7][aes_pkg::word_w-1 -: 8]} : w[3];
  assign sw_out = aes_pkg::sub_word(sw_in);

  always_comb begin
    n = w;
    if (phase) begin
      n[0] = w[0] ^ sw_out ^ {rcon, {(aes_pkg::word_w - 8){1'b0}}};
      n[1] = w[1] ^ n[0];
      n[2] = w[2] ^ n[1];
      n[3] = w[3] ^ n[2];
    end else begin
      n[4] = w[4] ^ sw_out;
      n[5] = w[5] ^ n[4];
      n[6] = w[6] ^ n[5];
      n[7] = w[7] ^ n[6];
    end
  end

  assign round_key = load  ? key[aes_pkg::key_w-1 -: aes_pkg::block_w] :
                     phase ? window[aes_pkg::block_w-1:0] :
                             window[aes_pkg::key_w-1 -: aes_pkg::block_w];

  // rcon runs 01 to 40 over the seven even steps
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rcon  <= 8'h01;
      phase <= 1'b0;
    end else if (load) begin
      rcon  <= 8'h01;
      phase <= 1'b1;
    end else if (step) begin
      if (phase) begin
        rcon <= {rcon[6:0], 1'b0};
      end
      phase <= !phase;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      window <= key;
    end else if (step) begin
      window <= n;
    end
  end

endmodule

/* design/aes_pkg.sv */
// AES-256 cipher constants and byte substitution helpers
// Forward S-box only because the core encrypts and never decrypts
// The table is the FIPS-197 S-box with row 0 in the top bits

package aes_pkg;

  localparam int block_w     = 128;
  localparam int key_w       = 256;
  localparam int word_w      = 32;
  localparam int num_rounds  = 14;
  localparam int round_cnt_w = 4;

  // ----------------------------------------
  // Forward substitution table
  // ----------------------------------------
  localparam logic [256*8-1:0] sbox_table = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  // Byte 00 sits in the most significant byte of the table
  function automatic logic [7:0] sbox(input logic [7:0] b);
    return sbox_table[(255 - int'(b)) * 8 +: 8];
  endfunction

  // SubWord applies the S-box to each byte of a key word
  function automatic logic [word_w-1:0] sub_word(input logic [word_w-1:0] w);
    logic [word_w-1:0] r;
    for (int i = 0; i < word_w / 8; i++) begin
      r[i*8 +: 8] = sbox(w[i*8 +: 8]);
    end
    return r;
  endfunction

endpackage

/* design/aes_result.sv */
// Result register with a valid/ready output handshake
// Holds out_valid and data_out until out_ready
// Bypass and done never arrive while a result is pending

module aes_result (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        bypass,
  input  logic                        done,
  input  logic [aes_pkg::block_w-1:0] cipher,
  output logic                        out_valid,
  input  logic                        out_ready,
  output logic [aes_pkg::block_w-1:0] data_out,
  output logic                        idle
);

  assign idle = !out_valid;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
      data_out  <= '0;
    end else if (bypass || done) begin
      out_valid <= 1'b1;
      data_out  <= done ? cipher : '0;
    end else if (out_valid && out_ready) begin
      // Delivered, the value stays but is no longer valid
      out_valid <= 1'b0;
    end
  end

endmodule

/* design/aes_round_engine.sv */
// Iterative AES-256 encryption, one round per clock
// Start is taken only while idle
// Done pulses for one cycle and cipher holds until the next start

module aes_round_engine (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        start,
  input  logic [aes_pkg::block_w-1:0] start_block,
  input  logic [aes_pkg::key_w-1:0]   start_key,
  output logic                        idle,
  output logic                        done,
  output logic [aes_pkg::block_w-1:0] cipher
);

  logic [aes_pkg::block_w-1:0]     state_q;
  logic [aes_pkg::block_w-1:0]     round_key;
  logic [aes_pkg::block_w-1:0]     sub_out;
  logic [aes_pkg::block_w-1:0]     shift_out;
  logic [aes_pkg::block_w-1:0]     mix_out;
  logic [aes_pkg::block_w-1:0]     round_out;
  logic [aes_pkg::round_cnt_w-1:0] round_q;
  logic                            running;
  logic                            load;
  logic                            last_round;

  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic logic [31:0] mix_column(input logic [31:0] col);
    logic [7:0] a0, a1, a2, a3;
    {a0, a1, a2, a3} = col;
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  // Column-major state, byte (row, col) at index 4*col + row from the top
  function automatic logic [aes_pkg::block_w-1:0] shift_rows(
    input logic [aes_pkg::block_w-1:0] s
  );
    logic [aes_pkg::block_w-1:0] r;
    for (int c = 0; c < 4; c++) begin
      for (int row = 0; row < 4; row++) begin
        r[aes_pkg::block_w-1-8*(4*c+row) -: 8] =
          s[aes_pkg::block_w-1-8*(4*((c+row)%4)+row) -: 8];
      end
    end
    return r;
  endfunction

  // ----------------------------------------
  // Round datapath
  // ----------------------------------------
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      sub_out[c*32 +: 32] = aes_pkg::sub_word(state_q[c*32 +: 32]);
    end
  end

  assign shift_out = shift_rows(sub_out);

  always_comb begin
    for (int c = 0; c < 4; c++) begin
      mix_out[c*32 +: 32] = mix_column(shift_out[c*32 +: 32]);
    end
  end

  // Final round skips MixColumns
  assign last_round = (int'(round_q) == aes_pkg::num_rounds - 1);
  assign round_out  = (last_round ? shift_out : mix_out) ^ round_key;

  aes_key_schedule u_key_schedule (
    .clk       (clk),
    .rst       (rst),
    .load      (load),
    .key       (start_key),
    .step      (running),
    .round_key (round_key)
  );

  // ----------------------------------------
  // Control
  // ----------------------------------------
  assign idle   = !running && !done;
  assign load   = start && idle;
  assign cipher = state_q;

  // round_q counts completed rounds
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      running <= 1'b0;
      done    <= 1'b0;
      round_q <= '0;
    end else begin
      done <= running && last_round;
      if (load) begin
        running <= 1'b1;
        round_q <= '0;
      end else if (running) begin
        if (last_round) begin
          running <= 1'b0;
        end else begin
          round_q <= round_q + 1'b1;
        end
      end
    end
  end

  // Initial AddRoundKey on load, then one round per cycle
  always_ff @(posedge clk) begin
    if (load) begin
      state_q <= start_block ^ round_key;
    end else if (running) begin
      state_q <= round_out;
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# Compile and run the AES-256 core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_aes_core -f aes_core.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_aes_core)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
exit 1

/* test/aes_core_asserts.sv */
// Handshake properties for the AES-256 core
// Bound into aes_core and checked only while reset is low

module aes_core_asserts (
  input logic                        clk,
  input logic                        rst,
  input logic                        in_ready,
  input logic                        busy,
  input logic                        out_valid,
  input logic                        out_ready,
  input logic [aes_pkg::block_w-1:0] data_out
);

  // Failed assertions, read by the testbench summary
  int unsigned failures = 0;

  // Result holds while the host stalls
  a_result_hold: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(data_out))
  ) else begin
    failures++;
    $error("out_valid or data_out changed while out_ready was low");
  end

  a_busy_inverse: assert property (
    @(posedge clk) disable iff (rst) busy == !in_ready
  ) else begin
    failures++;
    $error("busy is not the inverse of in_ready");
  end

  // No new command while a result is pending
  a_no_accept_pending: assert property (
    @(posedge clk) disable iff (rst) out_valid |-> !in_ready
  ) else begin
    failures++;
    $error("in_ready is high while out_valid is high");
  end

endmodule

/* test/tb_aes_core.sv */
// Directed testbench for the AES-256 core
// Known answers from FIPS-197 and SP 800-38A, AES-256 only
// Inputs change on the falling edge and outputs are read there too

module tb_aes_core;

  localparam int wait_limit = 100;

  localparam logic [aes_pkg::key_w-1:0] key_fips =
    256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;
  localparam logic [aes_pkg::block_w-1:0] pt_fips = 128'h00112233445566778899aabbccddeeff;
  localparam logic [aes_pkg::block_w-1:0] ct_fips = 128'h8ea2b7ca516745bfeafc49904b496089;
  localparam logic [aes_pkg::key_w-1:0] key_sp =
    256'h603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4;
  localparam logic [aes_pkg::block_w-1:0] pt_sp = 128'h6bc1bee22e409f96e93d7e117393172a;
  localparam logic [aes_pkg::block_w-1:0] ct_sp = 128'hf3eed1bdb5d2a03c064b5a7e3db181f8;

  logic                             clk;
  logic                             rst;
  logic                             in_valid;
  logic                             in_ready;
  logic [aes_cmd_pkg::opcode_w-1:0] opcode;
  aes_cmd_pkg::cmd_data_t           data_in;
  logic                             out_valid;
  logic                             out_ready;
  logic [aes_pkg::block_w-1:0]      data_out;
  logic                             busy;

  int errors;
  int tests_passed;
  int tests_failed;
  int test_start_errors;

  tb_clock u_clock (
    .clk (clk)
  );

  aes_core uut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .opcode    (opcode),
    .data_in   (data_in),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .data_out  (data_out),
    .busy      (busy)
  );

  bind aes_core aes_core_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .in_ready  (in_ready),
    .busy      (busy),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .data_out  (data_out)
  );

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  function automatic aes_cmd_pkg::cmd_data_t key_word(input logic [aes_pkg::key_w-1:0] k);
    aes_cmd_pkg::cmd_data_t d;
    d.key = k;
    return d;
  endfunction

  // Random filler in the unused lower half
  function automatic aes_cmd_pkg::cmd_data_t block_word(input logic [aes_pkg::block_w-1:0] pt);
    aes_cmd_pkg::cmd_data_t d;
    d.block.plaintext = pt;
    d.block.unused    = {$urandom, $urandom, $urandom, $urandom};
    return d;
  endfunction

  task automatic abort_run(input string reason);
    $display("Timeout: %s", reason);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  // Returns at the first falling edge after acceptance
  task automatic send_cmd(input logic [aes_cmd_pkg::opcode_w-1:0] op,
                          input aes_cmd_pkg::cmd_data_t data);
    int n;
    n = 0;
    in_valid = 1'b1;
    opcode   = op;
    data_in  = data;
    while (!in_ready) begin
      @(negedge clk);
      n++;
      if (n > wait_limit) abort_run("the core never accepted a command");
    end
    @(posedge clk);
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_result(output int cycles);
    int n;
    n = 0;
    while (!out_valid) begin
      if (busy !== 1'b1) begin
        $display("CHECK FAILED busy: got %0h expected 1", busy);
        errors++;
      end
      @(negedge clk);
      n++;
      if (n > wait_limit) abort_run("out_valid never rose after a command");
    end
    cycles = n;
  endtask

  task automatic deliver_result();
    out_ready = 1'b1;
    @(posedge clk);
    @(negedge clk);
    out_ready = 1'b0;
    if (out_valid !== 1'b0) begin
      $display("CHECK FAILED out_valid: got %0h expected 0", out_valid);
      errors++;
    end
    if (in_ready !== 1'b1) begin
      $display("CHECK FAILED in_ready: got %0h expected 1", in_ready);
      errors++;
    end
  endtask

  // Full command round trip with an optional output stall
  task automatic run_cmd(input logic [aes_cmd_pkg::opcode_w-1:0] op,
                         input aes_cmd_pkg::cmd_data_t data,
                         input logic [aes_pkg::block_w-1:0] expected,
                         input int exp_cycles,
                         input int stall);
    int cycles;
    send_cmd(op, data);
    wait_result(cycles);
    if (cycles != exp_cycles) begin
      $display("out_valid rose %0d cycles after acceptance, expected %0d", cycles, exp_cycles);
      errors++;
    end
    if (data_out !== expected) begin
      $display("CHECK FAILED data_out: got %h expected %h", data_out, expected);
      errors++;
    end
    for (int i = 0; i < stall; i++) begin
      @(negedge clk);
      if (out_valid !== 1'b1) begin
        $display("CHECK FAILED out_valid: got %0h expected 1", out_valid);
        errors++;
      end
      if (data_out !== expected) begin
        $display("CHECK FAILED data_out: got %h expected %h", data_out, expected);
        errors++;
      end
      if (in_ready !== 1'b0) begin
        $display("CHECK FAILED in_ready: got %0h expected 0", in_ready);
        errors++;
      end
    end
    deliver_result();
  endtask

  task automatic finish_test(input string name);
    if (errors == test_start_errors) begin
      $display("PASS %s", name);
      tests_passed++;
    end else begin
      $display("FAIL %s: %0d checks failed", name, errors - test_start_errors);
      tests_failed++;
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_reset_state();
    test_start_errors = errors;
    if (in_ready !== 1'b1) begin
      $display("CHECK FAILED in_ready: got %0h expected 1", in_ready);
      errors++;
    end
    if (busy !== 1'b0) begin
      $display("CHECK FAILED busy: got %0h expected 0", busy);
      errors++;
    end
    if (out_valid !== 1'b0) begin
      $display("CHECK FAILED out_valid: got %0h expected 0", out_valid);
      errors++;
    end
    if (data_out !== '0) begin
      $display("CHECK FAILED data_out: got %h expected 0", data_out);
      errors++;
    end
    finish_test("reset state");
  endtask

  task automatic test_key_load();
    test_start_errors = errors;
    run_cmd(aes_cmd_pkg::op_key_load, key_word(key_fips), '0, 1, 0);
    finish_test("key load");
  endtask

  task automatic test_fips_vector();
    test_start_errors = errors;
    run_cmd(aes_cmd_pkg::op_encrypt, block_word(pt_fips), ct_fips, 16, 0);
    finish_test("FIPS-197 vector");
  endtask

  // Two encrypts with different filler must agree
  task automatic test_key_replace();
    test_start_errors = errors;
    run_cmd(aes_cmd_pkg::op_key_load, key_word(key_sp), '0, 1, 0);
    run_cmd(aes_cmd_pkg::op_encrypt, block_word(pt_sp), ct_sp, 16, 0);
    run_cmd(aes_cmd_pkg::op_encrypt, block_word(pt_sp), ct_sp, 16, 0);
    finish_test("key replacement");
  endtask

  task automatic test_back_pressure();
    int stall;
    test_start_errors = errors;
    stall = 1 + int'($urandom % 20);
    run_cmd(aes_cmd_pkg::op_encrypt, block_word(pt_sp), ct_sp, 16, stall);
    finish_test("back-pressure");
  endtask

  // Random data with an unknown opcode must leave the key alone
  task automatic test_unknown_opcodes();
    aes_cmd_pkg::cmd_data_t junk;
    test_start_errors = errors;
    junk = key_word({$urandom, $urandom, $urandom, $urandom,
                     $urandom, $urandom, $urandom, $urandom});
    run_cmd(7'd2, junk, '0, 1, 0);
    run_cmd(7'h55, junk, '0, 1, 0);
    run_cmd(aes_cmd_pkg::op_encrypt, block_word(pt_sp), ct_sp, 16, 0);
    finish_test("unknown opcodes");
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    rst          = 1'b1;
    in_valid     = 1'b0;
    opcode       = '0;
    data_in      = '0;
    out_ready    = 1'b0;
    void'($urandom(36262));
    repeat (8) @(negedge clk);
    rst = 1'b0;

    test_reset_state();
    test_key_load();
    test_fips_vector();
    test_key_replace();
    test_back_pressure();
    test_unknown_opcodes();

    $display("Tests passed: %0d, tests failed: %0d, checks failed: %0d, assertions failed: %0d",
             tests_passed, tests_failed, errors, uut.u_asserts.failures);
    if (tests_failed == 0 && errors == 0 && uut.u_asserts.failures == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* test/tb_clock.sv */
// Free-running testbench clock with a period of 10 time units
// Starts low so the first rising edge comes at time 5

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

endmodule
